// ==== logic/cop_pkg.sv ====
// Shared definitions for the clock-24 game glue
// APB register offsets, SDRAM region bases, arbiter state codes
// and the ROM bank register

package cop_pkg;

    // SDRAM word address width
    localparam int addr_w = 22;

    // APB byte offsets, 4-bit address
    localparam logic [3:0] reg_mail_out  = 4'd0;
    localparam logic [3:0] reg_mail_in   = 4'd4;
    localparam logic [3:0] reg_snd_latch = 4'd8;
    localparam logic [3:0] reg_bank      = 4'd12;

    // SDRAM word bases of the ROM regions
    localparam logic [addr_w-1:0] snd_base = 22'h100000;
    localparam logic [addr_w-1:0] b0_base  = 22'h200000;

    // ROM arbiter states
    localparam logic [1:0] arb_idle = 2'd0;
    localparam logic [1:0] arb_req  = 2'd1;
    localparam logic [1:0] arb_wait = 2'd2;
    localparam logic [1:0] arb_done = 2'd3;

    // Bank register fields as seen by the mapper
    typedef struct packed {
        logic [3:0] spare;
        logic [1:0] snd_bank;
        logic [1:0] b0_bank;
    } cop_bank_fields_t;

    // CPU side sees a raw byte, mapper side sees fields
    typedef union packed {
        logic [7:0]       raw;
        cop_bank_fields_t f;
    } cop_bank_t;

endpackage

// ==== logic/cop_rom_if.sv ====
// ROM request channel between the bank mapper and the arbiter
// Client drives select and address, server returns data and ok

`timescale 1ns/1ps

interface cop_rom_if;

    logic                       cs;
    logic [cop_pkg::addr_w-1:0] addr;
    logic [15:0]                data;
    logic                       ok;

    // Request side, holds addr until ok
    modport client (
        output cs,
        output addr,
        input  data,
        input  ok
    );

    // Serving side, ok is a single-cycle pulse
    modport server (
        input  cs,
        input  addr,
        output data,
        output ok
    );

endinterface

// ==== logic/cop_mailbox.sv ====
// APB register block for the main CPU
// MCU mailbox with interrupt flag, sound latch and ROM bank register

`timescale 1ns/1ps

module cop_mailbox (
    input  logic              clk24,
    input  logic              rst24,
    // APB slave
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [3:0]        paddr,
    input  logic [15:0]       pwdata,
    output logic [15:0]       prdata,
    output logic              pready,
    // Protection MCU
    output logic              mcu_intn,
    input  logic              mcu_ack,
    input  logic              mcu_rd_hi,
    output logic [7:0]        mcu_rdata,
    input  logic              mcu_wr_hi,
    input  logic              mcu_wr_lo,
    input  logic [7:0]        mcu_wdata,
    // Sound CPU link
    output logic [7:0]        snd_latch,
    output logic              snreq,
    // ROM banking
    output cop_pkg::cop_bank_t bank
);

    logic        wr_en;
    logic        rd_en;
    logic [15:0] mail_out;
    logic [15:0] mail_in;

    // Access phase qualifiers
    assign wr_en  = psel & penable & pwrite;
    assign rd_en  = psel & penable & ~pwrite;
    assign pready = 1'b1;

    // CPU side registers
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            mail_out  <= '0;
            snd_latch <= '0;
            bank      <= '0;
            snreq     <= 1'b0;
        end else begin
            snreq <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    cop_pkg::reg_mail_out: mail_out <= pwdata;
                    cop_pkg::reg_snd_latch: begin
                        snd_latch <= pwdata[7:0];
                        snreq     <= 1'b1;
                    end
                    cop_pkg::reg_bank: bank.raw <= pwdata[7:0];
                    default: ;
                endcase
            end
        end
    end

    // Interrupt towards the MCU, a new mail beats the acknowledge
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            mcu_intn <= 1'b1;
        end else if (wr_en && paddr == cop_pkg::reg_mail_out) begin
            mcu_intn <= 1'b0;
        end else if (mcu_ack) begin
            mcu_intn <= 1'b1;
        end
    end

    // MCU writes its answer one byte lane at a time
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            mail_in <= '0;
        end else begin
            if (mcu_wr_hi) begin
                mail_in[15:8] <= mcu_wdata;
            end
            if (mcu_wr_lo) begin
                mail_in[7:0] <= mcu_wdata;
            end
        end
    end

    // MCU byte read, no latency
    assign mcu_rdata = mcu_rd_hi ? mail_out[15:8] : mail_out[7:0];

    // APB read mux
    always_comb begin
        prdata = '0;
        if (rd_en) begin
            case (paddr)
                cop_pkg::reg_mail_out:  prdata = mail_out;
                cop_pkg::reg_mail_in:   prdata = mail_in;
                cop_pkg::reg_snd_latch: prdata = {8'd0, snd_latch};
                cop_pkg::reg_bank:      prdata = {8'd0, bank.raw};
                default:                prdata = '0;
            endcase
        end
    end

endmodule

// ==== logic/cop_bank_map.sv ====
// ROM bank mapper for the sound CPU and background layer 0
// Adds bank bits and region bases, picks the sound byte lane

`timescale 1ns/1ps

module cop_bank_map (
    input  logic               clk24,
    input  logic               rst24,
    input  cop_pkg::cop_bank_t bank,
    // Sound CPU ROM
    input  logic               snd_cs,
    input  logic [15:0]        snd_addr,
    output logic [7:0]         snd_data,
    output logic               snd_ok,
    // Layer 0 ROM
    input  logic               b0rom_cs,
    input  logic [16:0]        b0rom_addr,
    output logic [15:0]        b0rom_data,
    output logic               b0rom_ok,
    // Towards the arbiter
    cop_rom_if.client          snd_ch,
    cop_rom_if.client          b0_ch
);

    logic                       snd_busy;
    logic                       b0_busy;
    logic [1:0]                 snd_bank_q;
    logic [1:0]                 b0_bank_q;
    logic [1:0]                 snd_bank_eff;
    logic [1:0]                 b0_bank_eff;
    logic [cop_pkg::addr_w-1:0] snd_off;
    logic [cop_pkg::addr_w-1:0] b0_off;

    // Request tracking, busy from the first cycle until ok
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            snd_busy <= 1'b0;
            b0_busy  <= 1'b0;
        end else begin
            if (snd_ch.ok) begin
                snd_busy <= 1'b0;
            end else if (snd_cs) begin
                snd_busy <= 1'b1;
            end
            if (b0_ch.ok) begin
                b0_busy <= 1'b0;
            end else if (b0rom_cs) begin
                b0_busy <= 1'b1;
            end
        end
    end

    // Bank fields frozen at the start of each request
    always_ff @(posedge clk24) begin
        if (snd_cs && !snd_busy) begin
            snd_bank_q <= bank.f.snd_bank;
        end
        if (b0rom_cs && !b0_busy) begin
            b0_bank_q <= bank.f.b0_bank;
        end
    end

    assign snd_bank_eff = snd_busy ? snd_bank_q : bank.f.snd_bank;
    assign b0_bank_eff  = b0_busy  ? b0_bank_q  : bank.f.b0_bank;

    // Sound ROM is byte wide, two bytes per SDRAM word
    assign snd_off = {5'd0, snd_bank_eff, snd_addr[15:1]};
    assign b0_off  = {3'd0, b0_bank_eff, b0rom_addr};

    assign snd_ch.cs   = snd_cs;
    assign snd_ch.addr = cop_pkg::snd_base + snd_off;
    assign b0_ch.cs    = b0rom_cs;
    assign b0_ch.addr  = cop_pkg::b0_base + b0_off;

    // Odd byte sits in the upper half
    assign snd_data   = snd_addr[0] ? snd_ch.data[15:8] : snd_ch.data[7:0];
    assign snd_ok     = snd_ch.ok;
    assign b0rom_data = b0_ch.data;
    assign b0rom_ok   = b0_ch.ok;

endmodule

// ==== logic/cop_rom_arbiter.sv ====
// Fixed-priority ROM arbiter for one SDRAM bank
// Sound channel first, layer 0 second, one access at a time

`timescale 1ns/1ps

module cop_rom_arbiter (
    input  logic                       clk24,
    input  logic                       rst24,
    // ROM channels
    cop_rom_if.server                  snd_ch,
    cop_rom_if.server                  b0_ch,
    // SDRAM bank port
    output logic [cop_pkg::addr_w-1:0] ba_addr,
    output logic                       ba_rd,
    input  logic                       ba_ack,
    input  logic                       ba_dok,
    input  logic [15:0]                data_read
);

    logic [1:0]  state;
    logic        gnt_b0;
    logic [15:0] data_q;

    // Grant is kept until the channel's ok
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            state  <= cop_pkg::arb_idle;
            gnt_b0 <= 1'b0;
        end else begin
            case (state)
                cop_pkg::arb_idle: begin
                    if (snd_ch.cs) begin
                        gnt_b0 <= 1'b0;
                        state  <= cop_pkg::arb_req;
                    end else if (b0_ch.cs) begin
                        gnt_b0 <= 1'b1;
                        state  <= cop_pkg::arb_req;
                    end
                end
                cop_pkg::arb_req: begin
                    // Data may follow the ack in the same cycle
                    if (ba_ack) begin
                        state <= ba_dok ? cop_pkg::arb_done : cop_pkg::arb_wait;
                    end
                end
                cop_pkg::arb_wait: begin
                    if (ba_dok) begin
                        state <= cop_pkg::arb_done;
                    end
                end
                default: begin
                    state <= cop_pkg::arb_idle;
                end
            endcase
        end
    end

    // Read word captured when the SDRAM flags it
    always_ff @(posedge clk24) begin
        if (ba_dok && (state == cop_pkg::arb_req || state == cop_pkg::arb_wait)) begin
            data_q <= data_read;
        end
    end

    assign ba_rd   = (state == cop_pkg::arb_req);
    assign ba_addr = gnt_b0 ? b0_ch.addr : snd_ch.addr;

    // Both channels see the same word, only the granted one gets ok
    assign snd_ch.data = data_q;
    assign b0_ch.data  = data_q;
    assign snd_ch.ok   = (state == cop_pkg::arb_done) & ~gnt_b0;
    assign b0_ch.ok    = (state == cop_pkg::arb_done) & gnt_b0;

endmodule

// ==== logic/cop_game.sv ====
// Top level of the clock-24 game glue
// Main CPU mailbox, ROM bank mapper and SDRAM ROM arbiter

`timescale 1ns/1ps

module cop_game (
    input  logic                       clk24,
    input  logic                       rst24,
    // Main CPU APB port
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [3:0]                 paddr,
    input  logic [15:0]                pwdata,
    output logic [15:0]                prdata,
    output logic                       pready,
    // Protection MCU
    output logic                       mcu_intn,
    input  logic                       mcu_ack,
    input  logic                       mcu_rd_hi,
    output logic [7:0]                 mcu_rdata,
    input  logic                       mcu_wr_hi,
    input  logic                       mcu_wr_lo,
    input  logic [7:0]                 mcu_wdata,
    // Sound CPU link
    output logic [7:0]                 snd_latch,
    output logic                       snreq,
    // Sound ROM
    input  logic                       snd_cs,
    input  logic [15:0]                snd_addr,
    output logic [7:0]                 snd_data,
    output logic                       snd_ok,
    // Layer 0 ROM
    input  logic                       b0rom_cs,
    input  logic [16:0]                b0rom_addr,
    output logic [15:0]                b0rom_data,
    output logic                       b0rom_ok,
    // SDRAM bank
    output logic [cop_pkg::addr_w-1:0] ba_addr,
    output logic                       ba_rd,
    input  logic                       ba_ack,
    input  logic                       ba_dok,
    input  logic [15:0]                data_read
);

    cop_pkg::cop_bank_t bank;

    cop_rom_if snd_ch ();
    cop_rom_if b0_ch ();

    cop_mailbox u_mailbox (
        .clk24      ( clk24      ),
        .rst24      ( rst24      ),
        .psel       ( psel       ),
        .penable    ( penable    ),
        .pwrite     ( pwrite     ),
        .paddr      ( paddr      ),
        .pwdata     ( pwdata     ),
        .prdata     ( prdata     ),
        .pready     ( pready     ),
        .mcu_intn   ( mcu_intn   ),
        .mcu_ack    ( mcu_ack    ),
        .mcu_rd_hi  ( mcu_rd_hi  ),
        .mcu_rdata  ( mcu_rdata  ),
        .mcu_wr_hi  ( mcu_wr_hi  ),
        .mcu_wr_lo  ( mcu_wr_lo  ),
        .mcu_wdata  ( mcu_wdata  ),
        .snd_latch  ( snd_latch  ),
        .snreq      ( snreq      ),
        .bank       ( bank       )
    );

    cop_bank_map u_bank_map (
        .clk24      ( clk24      ),
        .rst24      ( rst24      ),
        .bank       ( bank       ),
        .snd_cs     ( snd_cs     ),
        .snd_addr   ( snd_addr   ),
        .snd_data   ( snd_data   ),
        .snd_ok     ( snd_ok     ),
        .b0rom_cs   ( b0rom_cs   ),
        .b0rom_addr ( b0rom_addr ),
        .b0rom_data ( b0rom_data ),
        .b0rom_ok   ( b0rom_ok   ),
        .snd_ch     ( snd_ch     ),
        .b0_ch      ( b0_ch      )
    );

    cop_rom_arbiter u_rom_arbiter (
        .clk24      ( clk24      ),
        .rst24      ( rst24      ),
        .snd_ch     ( snd_ch     ),
        .b0_ch      ( b0_ch      ),
        .ba_addr    ( ba_addr    ),
        .ba_rd      ( ba_rd      ),
        .ba_ack     ( ba_ack     ),
        .ba_dok     ( ba_dok     ),
        .data_read  ( data_read  )
    );

endmodule

// ==== test/cop_game_assertions.sv ====
// Concurrent checks on the cop_game ports and bank register
// Reset state, APB ready, mailbox interrupt, sound latch pulse, ROM and SDRAM handshakes

`timescale 1ns/1ps

module cop_game_assertions (
    input logic                       clk24,
    input logic                       rst24,
    input logic                       psel,
    input logic                       penable,
    input logic                       pwrite,
    input logic [3:0]                 paddr,
    input logic [15:0]                pwdata,
    input logic                       pready,
    input logic                       mcu_intn,
    input logic                       mcu_ack,
    input logic                       mcu_rd_hi,
    input logic [7:0]                 mcu_rdata,
    input logic [7:0]                 snd_latch,
    input logic                       snreq,
    input logic                       snd_cs,
    input logic                       snd_ok,
    input logic                       b0rom_ok,
    input logic [cop_pkg::addr_w-1:0] ba_addr,
    input logic                       ba_rd,
    input logic                       ba_ack,
    input cop_pkg::cop_bank_t         bank
);

    int          fail_cnt = 0;
    logic        wr_mail;
    logic        wr_latch;
    logic        wr_bank;
    logic [15:0] mail_shadow;

    function automatic void count_fail(input string what);
        $error("%s", what);
        fail_cnt = fail_cnt + 1;
    endfunction

    assign wr_mail  = psel & penable & pwrite & (paddr == cop_pkg::reg_mail_out);
    assign wr_latch = psel & penable & pwrite & (paddr == cop_pkg::reg_snd_latch);
    assign wr_bank  = psel & penable & pwrite & (paddr == cop_pkg::reg_bank);

    // Last word the CPU put in the mailbox
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            mail_shadow <= '0;
        end else if (wr_mail) begin
            mail_shadow <= pwdata;
        end
    end

    a_reset_idle: assert property (@(posedge clk24)
        $fell(rst24) |-> mcu_intn && !snreq && !ba_rd && !snd_ok && !b0rom_ok)
        else count_fail("outputs not idle after reset");

    // No wait states on the APB port
    a_pready: assert property (@(posedge clk24) disable iff (rst24)
        psel && penable |-> pready)
        else count_fail("pready low in an APB access phase");

    // Interrupt set by mail and held until the acknowledge
    a_intn_set: assert property (@(posedge clk24) disable iff (rst24)
        wr_mail |=> !mcu_intn)
        else count_fail("mcu_intn not low after mailbox write");
    a_intn_hold: assert property (@(posedge clk24) disable iff (rst24)
        !mcu_intn && !mcu_ack |=> !mcu_intn)
        else count_fail("mcu_intn released without acknowledge");
    a_intn_clear: assert property (@(posedge clk24) disable iff (rst24)
        mcu_ack && !wr_mail |=> mcu_intn)
        else count_fail("mcu_intn still low after acknowledge");
    a_mcu_rdata: assert property (@(posedge clk24) disable iff (rst24)
        mcu_rdata == (mcu_rd_hi ? mail_shadow[15:8] : mail_shadow[7:0]))
        else count_fail("mcu_rdata does not show the selected mailbox byte");

    a_snreq_pulse: assert property (@(posedge clk24) disable iff (rst24)
        wr_latch |=> snreq && snd_latch == $past(pwdata[7:0]))
        else count_fail("sound latch write gave no request or wrong latch");
    a_snreq_cause: assert property (@(posedge clk24) disable iff (rst24)
        snreq |-> $past(wr_latch))
        else count_fail("snreq high without a latch write");
    a_bank_hold: assert property (@(posedge clk24) disable iff (rst24)
        !wr_bank |=> $stable(bank.raw))
        else count_fail("bank register changed without a write");

    // Sound wins when it waits at an idle arbiter
    a_snd_first: assert property (@(posedge clk24) disable iff (rst24)
        $rose(ba_rd) && $past(snd_cs) |-> ba_addr < cop_pkg::b0_base)
        else count_fail("layer 0 granted while sound was waiting");
    a_snd_ok_once: assert property (@(posedge clk24) disable iff (rst24)
        snd_ok |=> !snd_ok)
        else count_fail("snd_ok longer than one cycle");
    a_b0_ok_once: assert property (@(posedge clk24) disable iff (rst24)
        b0rom_ok |=> !b0rom_ok)
        else count_fail("b0rom_ok longer than one cycle");
    a_ba_hold: assert property (@(posedge clk24) disable iff (rst24)
        ba_rd && !ba_ack |=> ba_rd && $stable(ba_addr))
        else count_fail("SDRAM request dropped or moved before ba_ack");

endmodule

bind cop_game cop_game_assertions u_assertions (.*);

// ==== test/cop_game_tb.sv ====
// Testbench for the clock-24 game glue
// APB and MCU stimulus, SDRAM model with random latency, ROM clients

`timescale 1ns/1ps

module cop_game_tb;

    logic        clk24, rst24;
    logic        psel, penable, pwrite, pready;
    logic [3:0]  paddr;
    logic [15:0] pwdata, prdata;
    logic        mcu_intn, mcu_ack, mcu_rd_hi, mcu_wr_hi, mcu_wr_lo;
    logic [7:0]  mcu_rdata, mcu_wdata, snd_latch, snd_data, cur_bank;
    logic        snreq, snd_cs, snd_ok, b0rom_cs, b0rom_ok;
    logic [15:0] snd_addr, b0rom_data, data_read, w;
    logic [16:0] b0rom_addr;
    logic        ba_rd, ba_ack, ba_dok;
    logic [cop_pkg::addr_w-1:0] ba_addr, exp_snd_addr, exp_b0_addr;
    logic [31:0] lcg_state = 32'd85;
    int          err_cnt = 0;

    cop_game u_cop_game (.*);

    initial begin
        clk24 = 1'b0;
        forever #4 clk24 = ~clk24;
    end

    function automatic logic [15:0] rand_word();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic int rand_delay();
        logic [15:0] r;
        r = rand_word();
        return 1 + int'(r[1:0]);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic step_clock();
        @(posedge clk24);
        #1;
    endtask

    task automatic apb_write(input logic [3:0] a, input logic [15:0] d);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = a;
        pwdata = d;
        step_clock();
        penable = 1'b1;
        step_clock();
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        if (a == cop_pkg::reg_bank) begin
            cur_bank = d[7:0];
        end
    endtask

    task automatic apb_check(input logic [3:0] a, input logic [15:0] exp);
        psel = 1'b1;
        paddr = a;
        step_clock();
        penable = 1'b1;
        @(negedge clk24);
        check_val("prdata", {16'd0, prdata}, {16'd0, exp});
        step_clock();
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic mcu_write(input logic hi, input logic [7:0] d);
        mcu_wr_hi = hi;
        mcu_wr_lo = ~hi;
        mcu_wdata = d;
        step_clock();
        mcu_wr_hi = 1'b0;
        mcu_wr_lo = 1'b0;
    endtask

    // Sound ROM is byte wide, two bytes per SDRAM word
    task automatic snd_fetch(input logic [15:0] a);
        logic [15:0] word;
        exp_snd_addr = cop_pkg::snd_base + {5'd0, cur_bank[3:2], a[15:1]};
        word = exp_snd_addr[15:0] ^ 16'h5A5A;
        snd_cs = 1'b1;
        snd_addr = a;
        do @(negedge clk24); while (!snd_ok);
        check_val("snd_data", {24'd0, snd_data}, {24'd0, (a[0] ? word[15:8] : word[7:0])});
        step_clock();
        snd_cs = 1'b0;
    endtask

    task automatic b0_fetch(input logic [16:0] a);
        exp_b0_addr = cop_pkg::b0_base + {3'd0, cur_bank[1:0], a};
        b0rom_cs = 1'b1;
        b0rom_addr = a;
        do @(negedge clk24); while (!b0rom_ok);
        check_val("b0rom_data", {16'd0, b0rom_data}, {16'd0, exp_b0_addr[15:0] ^ 16'h5A5A});
        step_clock();
        b0rom_cs = 1'b0;
    endtask

    // SDRAM bank model, ack then data after random waits
    initial begin
        int ack_dly;
        int dok_dly;
        logic [15:0] word;
        ba_ack = 1'b0;
        ba_dok = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk24);
            if (ba_rd) begin
                ack_dly = rand_delay();
                dok_dly = rand_delay();
                repeat (ack_dly) @(posedge clk24);
                #1;
                if (ba_addr < cop_pkg::b0_base) begin
                    check_val("ba_addr", {10'd0, ba_addr}, {10'd0, exp_snd_addr});
                end else begin
                    check_val("ba_addr", {10'd0, ba_addr}, {10'd0, exp_b0_addr});
                end
                word = ba_addr[15:0] ^ 16'h5A5A;
                ba_ack = 1'b1;
                step_clock();
                ba_ack = 1'b0;
                repeat (dok_dly - 1) step_clock();
                ba_dok = 1'b1;
                data_read = word;
                step_clock();
                ba_dok = 1'b0;
            end
        end
    end

    initial begin
        int budget;
        // Reset, mailbox, latch and bank, sound loop, paired fetches, bank change, tail
        budget = 7 + 20 + 14 + 4 * 24 + 2 * 22 + 24 + 4;
        repeat (40 * budget) @(posedge clk24);
        $display("Timeout: a ROM fetch or APB access never completed");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst24 = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        mcu_ack = 1'b0;
        mcu_rd_hi = 1'b0;
        mcu_wr_hi = 1'b0;
        mcu_wr_lo = 1'b0;
        mcu_wdata = '0;
        snd_cs = 1'b0;
        snd_addr = '0;
        b0rom_cs = 1'b0;
        b0rom_addr = '0;
        cur_bank = '0;
        repeat (5) @(posedge clk24);
        #1;
        rst24 = 1'b0;
        repeat (2) step_clock();

        // Mailbox to the MCU and its answer
        apb_write(cop_pkg::reg_mail_out, 16'hC35A);
        mcu_rd_hi = 1'b1;
        step_clock();
        mcu_rd_hi = 1'b0;
        repeat (2) step_clock();
        mcu_ack = 1'b1;
        step_clock();
        mcu_ack = 1'b0;
        mcu_write(1'b1, 8'h9E);
        mcu_write(1'b0, 8'h21);
        apb_check(cop_pkg::reg_mail_in, 16'h9E21);
        apb_check(cop_pkg::reg_mail_out, 16'hC35A);

        // Sound latch and bank readback
        apb_write(cop_pkg::reg_snd_latch, 16'h0177);
        apb_check(cop_pkg::reg_snd_latch, 16'h0077);
        apb_write(cop_pkg::reg_bank, 16'h00B6);
        apb_check(cop_pkg::reg_bank, 16'h00B6);

        // Sound fetches over all sound banks, both byte lanes
        for (int i = 0; i < 4; i++) begin
            apb_write(cop_pkg::reg_bank, {8'd0, 4'hA, i[1:0], 2'd3 - i[1:0]});
            w = rand_word();
            snd_fetch({w[15:1], 1'b0});
            snd_fetch({w[15:1], 1'b1});
        end

        // Both clients at once
        for (int i = 0; i < 2; i++) begin
            w = rand_word();
            fork
                snd_fetch(w);
                b0_fetch({w[3], ~w});
            join
        end

        // Bank write while a layer 0 fetch is in flight
        w = rand_word();
        fork
            b0_fetch({1'b1, w});
            apb_write(cop_pkg::reg_bank, 16'h0002);
        join
        b0_fetch({1'b0, w});

        repeat (4) step_clock();
        $display("Errors: %0d compare, %0d assertion", err_cnt,
                 u_cop_game.u_assertions.fail_cnt);
        if (err_cnt == 0 && u_cop_game.u_assertions.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
logic/cop_pkg.sv
logic/cop_rom_if.sv
logic/cop_mailbox.sv
logic/cop_bank_map.sv
logic/cop_rom_arbiter.sv
logic/cop_game.sv
test/cop_game_assertions.sv
test/cop_game_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cop_game testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module cop_game_tb -f sim.f > sim.log 2>&1 \
    && ./obj_dir/Vcop_game_tb +verilator+error+limit+1000 >> sim.log 2>&1

cat sim.log
grep -q -e "TB FAILED" -e "%Error" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
